/* hdl/io_pkg.sv */
`default_nettype none

package io_pkg;

    localparam int OP_W   = 6;
    localparam int INST_W = 64;

    localparam logic [OP_W-1:0] OP_IN_LL  = 6'h10;
    localparam logic [OP_W-1:0] OP_IN_LH  = 6'h11;
    localparam logic [OP_W-1:0] OP_IN_UL  = 6'h12;
    localparam logic [OP_W-1:0] OP_IN_UH  = 6'h13;
    localparam logic [OP_W-1:0] OP_OUT_LL = 6'h14;

    localparam int QUEUE_DEPTH = 4;
    localparam int CREDIT_W    = 3;

    // input form with opcode and destination register
    typedef struct packed {
        logic [OP_W-1:0]          opcode;
        logic [4:0]               rt;
        logic [INST_W-OP_W-6:0]   unused;
    } in_form_t;

    // output form with the byte to send in the low lane
    typedef struct packed {
        logic [OP_W-1:0]          opcode;
        logic [INST_W-OP_W-9:0]   unused;
        logic [7:0]               wdata;
    } out_form_t;

    typedef union packed {
        in_form_t  in_form;
        out_form_t out_form;
    } io_inst_u;

    typedef struct packed {
        logic       is_read;
        logic [1:0] lane;
        logic [4:0] rt;
        logic [7:0] data;
    } io_req_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rt;
        logic [1:0] lane;
        logic [7:0] data;
    } io_resp_t;

endpackage

`default_nettype wire

/* hdl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ========================================
    // serial framing
    // ========================================
    localparam int CLKS_PER_BIT = 8;

    // start, 8 data bits lsb first, stop
    localparam int FRAME_BITS = 10;

    // ========================================
    // port sequencing
    // ========================================
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } port_state_e;

endpackage

`default_nettype wire

/* hdl/io_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module io_issue (
    input  logic               clk,
    input  logic               rstn,
    input  io_pkg::io_inst_u   inst,
    input  logic               inst_valid,
    input  io_pkg::io_resp_t   resp,
    input  logic               credit_return,
    output logic               stall,
    output logic               push,
    output io_pkg::io_req_t    push_req
);
    import io_pkg::*;

    logic                is_in;
    logic                is_out;
    logic [1:0]          lane;
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_nxt;
    logic                rd_pend;
    logic                rd_pend_nxt;

    // byte-lane reads
    always_comb begin
        is_in = 1'b1;
        lane  = 2'd0;
        case (inst.in_form.opcode)
            OP_IN_LL: lane = 2'd0;
            OP_IN_LH: lane = 2'd1;
            OP_IN_UL: lane = 2'd2;
            OP_IN_UH: lane = 2'd3;
            default:  is_in = 1'b0;
        endcase
    end

    assign is_out = (inst.out_form.opcode == OP_OUT_LL);

    // never issue without a free queue slot
    assign push = inst_valid && !stall && (credits != '0) && (is_in || is_out);

    always_comb begin
        push_req         = '0;
        push_req.is_read = is_in;
        push_req.lane    = lane;
        if (is_in) begin
            push_req.rt = inst.in_form.rt;
        end else begin
            push_req.data = inst.out_form.wdata;
        end
    end

    always_comb begin
        credits_nxt = credits;
        if (push && !credit_return) begin
            credits_nxt = credits - 1'b1;
        end else if (!push && credit_return) begin
            credits_nxt = credits + 1'b1;
        end
        rd_pend_nxt = rd_pend;
        if (push && is_in) begin
            rd_pend_nxt = 1'b1;
        end else if (resp.valid) begin
            rd_pend_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits <= CREDIT_W'(QUEUE_DEPTH);
            rd_pend <= 1'b0;
            stall   <= 1'b0;
        end else begin
            credits <= credits_nxt;
            rd_pend <= rd_pend_nxt;
            stall   <= rd_pend_nxt || (credits_nxt == '0);
        end
    end

endmodule

`default_nettype wire

/* hdl/io_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module io_req_queue (
    input  logic              clk,
    input  logic              rstn,
    input  logic              push,
    input  io_pkg::io_req_t   push_req,
    input  logic              pop,
    output io_pkg::io_req_t   head,
    output logic              head_valid,
    output logic              credit_return
);
    import io_pkg::*;

    io_req_t                          mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [CREDIT_W-1:0]              count;
    logic                             do_pop;

    assign head_valid    = (count != '0);
    assign head          = mem[rd_ptr];
    assign do_pop        = pop && head_valid;
    // one credit back per entry leaving
    assign credit_return = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_port.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_port (
    input  logic               clk,
    input  logic               rstn,
    input  io_pkg::io_req_t    head,
    input  logic               head_valid,
    output logic               pop,
    input  logic               tx_busy,
    output logic               tx_start,
    output logic [7:0]         tx_byte,
    input  logic               rx_full,
    input  logic [7:0]         rx_byte,
    output logic               rx_take,
    output io_pkg::io_resp_t   resp
);
    import io_pkg::*;
    import uart_pkg::*;

    port_state_e state;
    logic [4:0]  rd_rt;
    logic [1:0]  rd_lane;
    logic        resp_valid;
    logic [7:0]  resp_data;

    // ========================================
    // request hand-off
    // ========================================
    assign pop      = (state == IDLE) && head_valid && !tx_busy;
    assign tx_start = pop && !head.is_read;
    assign tx_byte  = head.data;
    assign rx_take  = (state == READ) && rx_full;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= head.is_read ? READ : WRITE;
                    end
                end
                WRITE: begin
                    // serdes raises busy the cycle after start
                    if (!tx_busy) begin
                        state <= IDLE;
                    end
                end
                READ: begin
                    if (rx_full) begin
                        resp_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // destination of the read in flight
    always_ff @(posedge clk) begin
        if (pop && head.is_read) begin
            rd_rt   <= head.rt;
            rd_lane <= head.lane;
        end
        if (rx_take) begin
            resp_data <= rx_byte;
        end
    end

    assign resp = '{valid: resp_valid, rt: rd_rt, lane: rd_lane, data: resp_data};

endmodule

`default_nettype wire

/* hdl/uart_serdes.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_serdes (
    input  logic       clk,
    input  logic       rstn,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       tx,
    input  logic       rx,
    output logic       rx_full,
    output logic [7:0] rx_byte,
    input  logic       rx_take
);
    import uart_pkg::*;

    logic [$clog2(CLKS_PER_BIT)-1:0] tx_clk;
    logic [$clog2(FRAME_BITS)-1:0]   tx_bit;
    logic [FRAME_BITS-2:0]           tx_shift;

    logic                            rx_s1;
    logic                            rx_s2;
    logic                            rx_active;
    logic [$clog2(CLKS_PER_BIT)-1:0] rx_clk;
    logic [$clog2(FRAME_BITS)-1:0]   rx_bit;
    logic [7:0]                      rx_shift;
    logic                            rx_sample;

    // ========================================
    // transmitter
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_busy <= 1'b0;
            tx      <= 1'b1;
            tx_clk  <= '0;
            tx_bit  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                tx      <= 1'b0;
                tx_clk  <= '0;
                tx_bit  <= '0;
            end
        end else if (tx_clk == CLKS_PER_BIT - 1) begin
            tx_clk <= '0;
            if (tx_bit == FRAME_BITS - 1) begin
                // line is already high after the stop bit
                tx_busy <= 1'b0;
            end else begin
                tx     <= tx_shift[0];
                tx_bit <= tx_bit + 1'b1;
            end
        end else begin
            tx_clk <= tx_clk + 1'b1;
        end
    end

    // data bits then stop bit
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            tx_shift <= {1'b1, tx_byte};
        end else if (tx_busy && tx_clk == CLKS_PER_BIT - 1) begin
            tx_shift <= {1'b1, tx_shift[FRAME_BITS-2:1]};
        end
    end

    // ========================================
    // receiver
    // ========================================
    assign rx_sample = rx_active && (rx_clk == CLKS_PER_BIT / 2 - 1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_s1     <= 1'b1;
            rx_s2     <= 1'b1;
            rx_active <= 1'b0;
            rx_clk    <= '0;
            rx_bit    <= '0;
            rx_full   <= 1'b0;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            if (rx_take) begin
                rx_full <= 1'b0;
            end
            if (!rx_active) begin
                if (!rx_s2) begin
                    rx_active <= 1'b1;
                    rx_clk    <= '0;
                    rx_bit    <= '0;
                end
            end else begin
                rx_clk <= (rx_clk == CLKS_PER_BIT - 1) ? '0 : rx_clk + 1'b1;
                if (rx_sample) begin
                    rx_bit <= rx_bit + 1'b1;
                    if (rx_bit == 0 && rx_s2) begin
                        // start bit too short to be real
                        rx_active <= 1'b0;
                    end else if (rx_bit == FRAME_BITS - 1) begin
                        rx_active <= 1'b0;
                        // bad stop bit drops the frame
                        if (rx_s2) begin
                            rx_full <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_sample && rx_bit != 0 && rx_bit != FRAME_BITS - 1) begin
            rx_shift <= {rx_s2, rx_shift[7:1]};
        end
        if (rx_sample && rx_bit == FRAME_BITS - 1 && rx_s2) begin
            rx_byte <= rx_shift;
        end
    end

endmodule

`default_nettype wire

/* hdl/io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module io_top (
    input  logic               clk,
    input  logic               rstn,
    input  io_pkg::io_inst_u   inst,
    input  logic               inst_valid,
    input  logic               rx,
    output logic               stall,
    output logic               tx,
    output io_pkg::io_resp_t   resp
);
    import io_pkg::*;

    logic       push;
    io_req_t    push_req;
    logic       credit_return;
    io_req_t    head;
    logic       head_valid;
    logic       pop;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       rx_full;
    logic [7:0] rx_byte;
    logic       rx_take;

    io_issue u_issue (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid), .resp(resp),
        .credit_return(credit_return), .stall(stall), .push(push), .push_req(push_req)
    );

    io_req_queue u_queue (
        .clk(clk), .rstn(rstn), .push(push), .push_req(push_req), .pop(pop),
        .head(head), .head_valid(head_valid), .credit_return(credit_return)
    );

    uart_port u_port (
        .clk(clk), .rstn(rstn), .head(head), .head_valid(head_valid), .pop(pop),
        .tx_busy(tx_busy), .tx_start(tx_start), .tx_byte(tx_byte),
        .rx_full(rx_full), .rx_byte(rx_byte), .rx_take(rx_take), .resp(resp)
    );

    uart_serdes u_serdes (
        .clk(clk), .rstn(rstn), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_busy(tx_busy), .tx(tx), .rx(rx), .rx_full(rx_full),
        .rx_byte(rx_byte), .rx_take(rx_take)
    );

endmodule

`default_nettype wire

/* dv/io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module io_tb;
    import io_pkg::*;
    import uart_pkg::*;

    // tx frames plus rx frames sent by the tests
    localparam int FRAMES         = 11;
    localparam int TIMEOUT_CYCLES = FRAMES * FRAME_BITS * CLKS_PER_BIT + 600;

    logic       clk;
    logic       rstn;
    io_inst_u   inst;
    logic       inst_valid;
    logic       rx;
    logic       stall;
    logic       tx;
    io_resp_t   resp;

    int         errors;
    int         cycles;
    logic [31:0] rng;
    logic       stall_seen;
    logic [7:0] tx_seen [$];

    io_top uut (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid), .rx(rx),
        .stall(stall), .tx(tx), .resp(resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("FAIL %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        errors++;
    endtask

    // ========================================
    // serial models
    // ========================================
    task automatic capture_tx_frame();
        logic [7:0] b;
        int         i;
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("tx start bit at %0t did not stay low to mid-bit", $time);
            errors++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1) begin
            $display("tx frame at %0t has a low stop bit", $time);
            errors++;
        end
        tx_seen.push_back(b);
    endtask

    task automatic send_frame(input logic [7:0] b);
        int i;
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    // holds the word until an edge with stall low takes it
    task automatic issue(input io_inst_u word);
        inst       = word;
        inst_valid = 1'b1;
        while (stall) begin
            stall_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic await_resp(input logic [7:0] data, input logic [4:0] rt,
                              input logic [1:0] lane);
        while (resp.valid !== 1'b1) begin
            if (stall !== 1'b1) begin
                report_value("stall", 1, stall);
            end
            @(posedge clk);
            #1;
        end
        if (resp.data !== data) begin
            report_value("resp.data", data, resp.data);
        end
        if (resp.rt !== rt) begin
            report_value("resp.rt", rt, resp.rt);
        end
        if (resp.lane !== lane) begin
            report_value("resp.lane", lane, resp.lane);
        end
        if (stall !== 1'b1) begin
            report_value("stall", 1, stall);
        end
        @(posedge clk);
        #1;
        if (resp.valid !== 1'b0) begin
            report_value("resp.valid", 0, resp.valid);
        end
        if (stall !== 1'b0) begin
            report_value("stall", 0, stall);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic check_idle(input int n);
        repeat (n) begin
            if (stall !== 1'b0) begin
                report_value("stall", 0, stall);
            end
            if (resp.valid !== 1'b0) begin
                report_value("resp.valid", 0, resp.valid);
            end
            if (tx !== 1'b1) begin
                report_value("tx", 1, tx);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_out_bytes(input int n);
        logic [7:0] sent [$];
        io_inst_u   word;
        int         i;
        tx_seen.delete();
        stall_seen = 1'b0;
        for (i = 0; i < n; i++) begin
            rng = xorshift(rng);
            sent.push_back(rng[7:0]);
            word = '0;
            word.out_form.opcode = OP_OUT_LL;
            word.out_form.wdata  = rng[7:0];
            issue(word);
        end
        // more outputs than queue slots must run out of credits
        if (n > QUEUE_DEPTH && !stall_seen) begin
            $display("stall never rose while %0d outputs were issued back to back", n);
            errors++;
        end
        while (tx_seen.size() < n) begin
            @(posedge clk);
            #1;
        end
        repeat (FRAME_BITS * CLKS_PER_BIT) @(posedge clk);
        #1;
        if (tx_seen.size() != n) begin
            report_value("tx frame count", n, tx_seen.size());
        end
        for (i = 0; i < n; i++) begin
            if (tx_seen[i] !== sent[i]) begin
                report_value($sformatf("tx byte %0d", i), sent[i], tx_seen[i]);
            end
        end
    endtask

    task automatic test_byte_reads();
        logic [OP_W-1:0] ops [4];
        io_inst_u        word;
        logic [4:0]      rt;
        logic [7:0]      b;
        int              i;
        ops = '{OP_IN_LL, OP_IN_LH, OP_IN_UL, OP_IN_UH};
        for (i = 0; i < 4; i++) begin
            rng  = xorshift(rng);
            rt   = rng[12:8];
            b    = rng[7:0];
            word = '0;
            word.in_form.opcode = ops[i];
            word.in_form.rt     = rt;
            issue(word);
            if (stall !== 1'b1) begin
                report_value("stall", 1, stall);
            end
            fork
                send_frame(b);
                await_resp(b, rt, 2'(i));
            join
        end
    endtask

    task automatic test_non_io();
        io_inst_u word;
        tx_seen.delete();
        word = '0;
        word.in_form.opcode = 6'h05;
        word.in_form.rt     = 5'd3;
        inst       = word;
        inst_valid = 1'b1;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        check_idle(FRAME_BITS * CLKS_PER_BIT);
        if (tx_seen.size() != 0) begin
            report_value("tx frame count", 0, tx_seen.size());
        end
    endtask

    // ========================================
    // run control
    // ========================================
    initial begin
        @(posedge rstn);
        forever capture_tx_frame();
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        errors     = 0;
        rng        = 32'd97;
        stall_seen = 1'b0;
        rstn       = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        rx         = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_idle(16);
        test_out_bytes(1);
        test_out_bytes(6);
        test_byte_reads();
        test_non_io();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/io_pkg.sv
hdl/uart_pkg.sv
hdl/io_issue.sv
hdl/io_req_queue.sv
hdl/uart_port.sv
hdl/uart_serdes.sv
hdl/io_top.sv
dv/io_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= io_tb
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: sim clean
